/* flash_pkg.sv */
package flash_pkg;

	localparam int WORD_BITS = 22; // flash word address width, both chips
	localparam int REG_BITS  = 4;  // register index width

	// register map, reg space
	localparam logic [REG_BITS-1:0] REG_STATUS = 4'd0;
	localparam logic [REG_BITS-1:0] REG_COUNT  = 4'd1;

	// array view of the bus address
	typedef struct packed {
		logic                 space; // 0 selects the array
		logic                 chip;  // which of the two parallel chips
		logic [WORD_BITS-1:0] word;  // 32-bit word address inside the chip
		logic [7:0]           rsvd;  // ignored
	} arr_addr_t;

	// register view of the same word
	typedef struct packed {
		logic                     space; // 1 selects the registers
		logic [31-REG_BITS-1:0]   rsvd;  // ignored
		logic [REG_BITS-1:0]      idx;   // register index
	} reg_addr_t;

	typedef union packed {
		arr_addr_t arr;
		reg_addr_t regs;
	} wb_addr_u;

	typedef enum logic [1:0] {
		kind_arr, // timed chip read
		kind_reg, // status or counter
		kind_wr   // acked and dropped
	} flash_kind_e;

	// decoded request, decode -> engine and result
	typedef struct packed {
		flash_kind_e          kind;
		logic                 chip;
		logic [WORD_BITS-1:0] word;
		logic [REG_BITS-1:0]  idx;
	} flash_req_t;

	// array read result, engine -> result
	typedef struct packed {
		logic        valid; // one cycle per finished read
		logic [31:0] data;
	} flash_res_t;

endpackage

/* flash_addr_decode.sv */
`timescale 1ns/1ns

module flash_addr_decode (
	input  logic                  clk_bus,
	input  logic                  rst,
	input  logic                  wbs_cyc_i,
	input  logic                  wbs_stb_i,
	input  logic                  wbs_we_i,
	input  flash_pkg::wb_addr_u   wbs_adr_i,
	input  logic                  ack_i,       // end of the bus cycle
	output flash_pkg::flash_req_t req_o,
	output logic                  req_valid_o
	);

	import flash_pkg::*;

	logic       locked; // request taken, waiting for ack
	logic       fire;
	flash_req_t req_d;

	assign fire = wbs_cyc_i & wbs_stb_i & ~locked; // first cycle of a new bus cycle

	// classify by the space bit, then read the matching view
	always_comb begin
		req_d = '0;
		if (wbs_we_i) begin
			req_d.kind = kind_wr; // nothing is written, address not needed
		end else if (wbs_adr_i.arr.space == 1'b0) begin
			req_d.kind = kind_arr;
			req_d.chip = wbs_adr_i.arr.chip;
			req_d.word = wbs_adr_i.arr.word;
		end else begin
			req_d.kind = kind_reg;
			req_d.idx  = wbs_adr_i.regs.idx;
		end
	end

	always_ff @(posedge clk_bus) begin
		if (rst) begin
			locked      <= 1'b0;
			req_valid_o <= 1'b0;
		end else begin
			req_valid_o <= fire; // single pulse per bus cycle
			if (fire)
				locked <= 1'b1;
			else if (ack_i)
				locked <= 1'b0; // stb drops the cycle after ack
		end
	end

	// request payload, only meaningful with req_valid_o
	always_ff @(posedge clk_bus) begin
		if (fire)
			req_o <= req_d;
	end

endmodule

/* flash_read_engine.sv */
`timescale 1ns/1ns

module flash_read_engine #(
	parameter int ACCESS_CYCLES = 6,  // fixed wait after ce/oe fall
	parameter int RESET_CYCLES  = 20  // flash reset pulse length
	) (
	input  logic                             clk_bus,
	input  logic                             rst,
	input  flash_pkg::flash_req_t            req_i,
	input  logic                             req_valid_i,
	output flash_pkg::flash_res_t            rd_o,
	output logic                             busy_o,
	output logic                             flash_rst_n_o,
	output logic [1:0]                       flash_ce_n_o,
	output logic                             flash_oe_n_o,
	output logic [flash_pkg::WORD_BITS-1:0]  flash_addr_o,
	input  logic [1:0]                       flash_ready_i,
	input  logic [31:0]                      flash_din_i
	);

	import flash_pkg::*;

	localparam int CNT_BITS = $clog2(RESET_CYCLES + ACCESS_CYCLES + 1);
	localparam logic [CNT_BITS-1:0] RST_LAST = CNT_BITS'(RESET_CYCLES - 1);
	localparam logic [CNT_BITS-1:0] ACC_LAST = CNT_BITS'(ACCESS_CYCLES - 1);

	typedef enum logic [2:0] {
		S_RST,  // flash reset pin held low
		S_IDLE,
		S_ACC,  // fixed access time
		S_RDY,  // wait for the chip's ready line
		S_SMP   // data bus stable, take the word
	} state_e;

	state_e               state;
	logic [CNT_BITS-1:0]  cnt;
	logic                 pend;       // array request waiting to start
	logic                 cur_chip;
	logic [WORD_BITS-1:0] cur_word;
	logic [1:0]           ready_s1;   // ready lines are async to clk_bus
	logic [1:0]           ready_s2;
	logic                 in_access;

	assign in_access     = (state == S_ACC) || (state == S_RDY) || (state == S_SMP);
	assign flash_rst_n_o = (state != S_RST);
	assign flash_ce_n_o  = in_access ? ~(2'b01 << cur_chip) : 2'b11; // only one chip at a time
	assign flash_oe_n_o  = ~in_access;
	assign flash_addr_o  = cur_word;
	assign busy_o        = (state != S_IDLE) | pend; // also high through the reset pulse

	always_ff @(posedge clk_bus) begin
		ready_s1 <= flash_ready_i;
		ready_s2 <= ready_s1;
	end

	always_ff @(posedge clk_bus) begin
		if (rst) begin
			state      <= S_RST;
			cnt        <= '0;
			pend       <= 1'b0;
			rd_o.valid <= 1'b0;
		end else begin
			rd_o.valid <= 1'b0;
			if (req_valid_i && req_i.kind == kind_arr)
				pend <= 1'b1; // kept through reset hold
			case (state)
				S_RST: begin
					cnt <= cnt + 1'b1;
					if (cnt == RST_LAST)
						state <= S_IDLE;
				end
				S_IDLE: begin
					cnt <= '0;
					if (pend) begin
						pend  <= 1'b0;
						state <= S_ACC;
					end
				end
				S_ACC: begin
					cnt <= cnt + 1'b1;
					if (cnt == ACC_LAST)
						state <= S_RDY;
				end
				S_RDY: if (ready_s2[cur_chip]) state <= S_SMP;
				S_SMP: begin
					rd_o.valid <= 1'b1; // data registered on this edge too
					state      <= S_IDLE;
				end
				default: state <= S_IDLE;
			endcase
		end
	end

	// address latch and data capture, no reset needed
	always_ff @(posedge clk_bus) begin
		if (req_valid_i && req_i.kind == kind_arr) begin
			cur_chip <= req_i.chip;
			cur_word <= req_i.word;
		end
		if (state == S_SMP)
			rd_o.data <= flash_din_i;
	end

endmodule

/* flash_result_latch.sv */
`timescale 1ns/1ns

module flash_result_latch (
	input  logic                  clk_bus,
	input  logic                  rst,
	input  flash_pkg::flash_req_t req_i,
	input  logic                  req_valid_i,
	input  flash_pkg::flash_res_t rd_i,
	input  logic                  busy_i,
	input  logic [1:0]            flash_ready_i,
	output logic [31:0]           wbs_dat_o,
	output logic                  wbs_ack_o
	);

	import flash_pkg::*;

	logic [15:0] rd_count;  // finished array reads
	logic [31:0] status;
	logic [31:0] reg_word;
	logic        quick;     // answered straight from decode

	assign status = {29'd0, flash_ready_i, busy_i};
	assign quick  = req_valid_i && (req_i.kind != kind_arr);

	always_comb begin
		case (req_i.idx)
			REG_STATUS: reg_word = status;
			REG_COUNT:  reg_word = {16'd0, rd_count};
			default:    reg_word = 32'd0; // unmapped index reads zero
		endcase
	end

	always_ff @(posedge clk_bus) begin
		if (rst) begin
			wbs_ack_o <= 1'b0;
			rd_count  <= '0;
		end else begin
			wbs_ack_o <= quick | rd_i.valid; // one cycle, stb still held
			if (rd_i.valid)
				rd_count <= rd_count + 1'b1;
		end
	end

	// bus data holds until the next ack
	always_ff @(posedge clk_bus) begin
		if (rd_i.valid)
			wbs_dat_o <= rd_i.data;
		else if (quick)
			wbs_dat_o <= (req_i.kind == kind_reg) ? reg_word : 32'd0; // writes read back 0
	end

endmodule

/* wb_flash_reader.sv */
`timescale 1ns/1ns

module wb_flash_reader #(
	parameter int ACCESS_CYCLES = 6,
	parameter int RESET_CYCLES  = 20
	) (
	input  logic                            clk_bus,
	input  logic                            rst,
	// wishbone slave
	input  logic                            wbs_cyc_i,
	input  logic                            wbs_stb_i,
	input  logic                            wbs_we_i,
	input  logic [31:0]                     wbs_adr_i,
	input  logic [3:0]                      wbs_sel_i,
	output logic [31:0]                     wbs_dat_o,
	output logic                            wbs_ack_o,
	// flash pins, both chips share address and data
	output logic                            flash_rst_n_o,
	output logic [1:0]                      flash_ce_n_o,
	output logic                            flash_oe_n_o,
	output logic [flash_pkg::WORD_BITS-1:0] flash_addr_o,
	input  logic [1:0]                      flash_ready_i,
	input  logic [31:0]                     flash_din_i
	);

	import flash_pkg::*;

	flash_req_t req;
	logic       req_valid;
	flash_res_t rd;
	logic       busy;
	logic       no_read;   // write, or no byte lane enabled

	assign no_read = wbs_we_i | (wbs_sel_i == 4'b0000); // answered like a write

	flash_addr_decode u_decode (
		.clk_bus(clk_bus), .rst(rst),
		.wbs_cyc_i(wbs_cyc_i), .wbs_stb_i(wbs_stb_i), .wbs_we_i(no_read),
		.wbs_adr_i(wbs_adr_i), .ack_i(wbs_ack_o),
		.req_o(req), .req_valid_o(req_valid)
	);

	flash_read_engine #(.ACCESS_CYCLES(ACCESS_CYCLES), .RESET_CYCLES(RESET_CYCLES)) u_engine (
		.clk_bus(clk_bus), .rst(rst),
		.req_i(req), .req_valid_i(req_valid), .rd_o(rd), .busy_o(busy),
		.flash_rst_n_o(flash_rst_n_o), .flash_ce_n_o(flash_ce_n_o),
		.flash_oe_n_o(flash_oe_n_o), .flash_addr_o(flash_addr_o),
		.flash_ready_i(flash_ready_i), .flash_din_i(flash_din_i)
	);

	flash_result_latch u_result (
		.clk_bus(clk_bus), .rst(rst),
		.req_i(req), .req_valid_i(req_valid), .rd_i(rd), .busy_i(busy),
		.flash_ready_i(flash_ready_i),
		.wbs_dat_o(wbs_dat_o), .wbs_ack_o(wbs_ack_o)
	);

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
	output logic clk_o,
	output logic rst_o
	);

	initial begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o; // 8 ns period
	end

	initial begin
		rst_o = 1'b1;
		repeat (3) @(posedge clk_o);
		#1 rst_o = 1'b0; // released off the edge like the other inputs
	end

endmodule

/* tb_flash_model.sv */
`timescale 1ns/1ns

module tb_flash_model (
	input  logic        clk_i,
	input  logic [1:0]  ce_n_i,
	input  logic        oe_n_i,
	input  logic [21:0] addr_i,
	input  int          delay_i,  // ready low time in cycles, per read
	output logic [1:0]  ready_o,
	output logic [31:0] din_o
	);

	int chip;

	initial ready_o = 2'b11;

	// chip 1 carries a fixed pattern so the two chips are told apart
	assign din_o = (ce_n_i[1] == 1'b0) ? ({10'd0, addr_i} ^ 32'hA5A50000) : {10'd0, addr_i};

	always @(negedge oe_n_i) begin
		#1;
		chip = ce_n_i[1] ? 0 : 1;
		if (delay_i > 0) begin
			ready_o[chip] = 1'b0; // busy after oe falls
			repeat (delay_i) @(posedge clk_i);
			#1 ready_o[chip] = 1'b1;
		end
	end

endmodule

/* wb_flash_reader_properties.sv */
`timescale 1ns/1ns

module wb_flash_reader_properties (
	input logic       clk_bus,
	input logic       rst,
	input logic       wbs_stb_i,
	input logic       wbs_ack_o,
	input logic [1:0] flash_ce_n_o,
	input logic       flash_oe_n_o
	);

	// ack only answers a live strobe
	ack_needs_stb: assert property (@(posedge clk_bus) disable iff (rst)
		wbs_ack_o |-> wbs_stb_i)
		else $error("ack without stb");

	one_chip: assert property (@(posedge clk_bus) disable iff (rst)
		flash_ce_n_o != 2'b00)
		else $error("both chip enables low");

	oe_with_ce: assert property (@(posedge clk_bus) disable iff (rst)
		!flash_oe_n_o |-> $onehot(~flash_ce_n_o))
		else $error("output enable low without exactly one chip enabled");

endmodule

bind wb_flash_reader wb_flash_reader_properties u_props (
	.clk_bus(clk_bus), .rst(rst), .wbs_stb_i(wbs_stb_i), .wbs_ack_o(wbs_ack_o),
	.flash_ce_n_o(flash_ce_n_o), .flash_oe_n_o(flash_oe_n_o)
);

/* tb_wb_flash_reader.sv */
`timescale 1ns/1ns

module tb_wb_flash_reader;

	localparam int ACCESS_CYCLES = 6;
	localparam int RESET_CYCLES  = 20;
	localparam int N             = 17;
	localparam int K_ARR = 0, K_REG = 1, K_WR = 2, K_RND = 3; // entry kinds
	localparam int E_MODEL = 0, E_FIXED = 1, E_COUNT = 2;     // how to expect

	logic        clk_bus, rst;
	logic        cyc, stb, we;
	logic [31:0] adr;
	logic [3:0]  sel;
	logic [31:0] wbs_dat_o;
	logic        wbs_ack_o;
	logic        flash_rst_n, flash_oe_n;
	logic [1:0]  flash_ce_n, flash_ready;
	logic [21:0] flash_addr;
	logic [31:0] flash_din;
	int          model_delay;

	int          kind_t [N];
	logic [31:0] addr_t [N];
	int          delay_t [N];
	int          mode_t [N];
	logic [31:0] val_t [N];

	int          errors, passed, arr_done, cycles, limit;
	logic [15:0] lfsr;

	tb_clock_gen u_clk (.clk_o(clk_bus), .rst_o(rst));

	tb_flash_model u_flash (
		.clk_i(clk_bus), .ce_n_i(flash_ce_n), .oe_n_i(flash_oe_n), .addr_i(flash_addr),
		.delay_i(model_delay), .ready_o(flash_ready), .din_o(flash_din)
	);

	wb_flash_reader #(.ACCESS_CYCLES(ACCESS_CYCLES), .RESET_CYCLES(RESET_CYCLES)) UUT (
		.clk_bus(clk_bus), .rst(rst),
		.wbs_cyc_i(cyc), .wbs_stb_i(stb), .wbs_we_i(we), .wbs_adr_i(adr), .wbs_sel_i(sel),
		.wbs_dat_o(wbs_dat_o), .wbs_ack_o(wbs_ack_o),
		.flash_rst_n_o(flash_rst_n), .flash_ce_n_o(flash_ce_n), .flash_oe_n_o(flash_oe_n),
		.flash_addr_o(flash_addr), .flash_ready_i(flash_ready), .flash_din_i(flash_din)
	);

	function automatic logic [31:0] arr_addr(input logic chip, input logic [21:0] word);
		return {1'b0, chip, word, 8'h00};
	endfunction

	// data rule of the two chips
	function automatic logic [31:0] chip_word(input logic [31:0] a);
		logic [31:0] w;
		w = {10'd0, a[29:8]};
		return a[30] ? (w ^ 32'hA5A50000) : w;
	endfunction

	// 16-bit fibonacci, taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic rnd_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int b = 0; b < n; b++) begin
			v = {v[30:0], lfsr[15]}; // one step per bit
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// one row of the table
	task automatic set_entry(input int i, input int kind, input logic [31:0] a, input int dly,
		input int mode, input logic [31:0] v);
		kind_t[i]  = kind;
		addr_t[i]  = a;
		delay_t[i] = dly;
		mode_t[i]  = mode;
		val_t[i]   = v;
	endtask

	task automatic load_table;
		logic [31:0] r;
		set_entry(0, K_ARR, arr_addr(1'b0, 22'h000123), 2, E_MODEL, '0); // during flash reset
		set_entry(1, K_REG, 32'h8000_0000, 0, E_FIXED, 32'h6); // both ready, not busy
		set_entry(2, K_ARR, arr_addr(1'b0, 22'h3ABCDE), 3, E_MODEL, '0);
		set_entry(3, K_ARR, arr_addr(1'b1, 22'h000123), 3, E_MODEL, '0);
		set_entry(4, K_ARR, arr_addr(1'b1, 22'h155555), 25, E_MODEL, '0); // long ready wait
		set_entry(5, K_REG, 32'h8000_0001, 0, E_COUNT, '0);
		set_entry(6, K_WR, arr_addr(1'b0, 22'h000010), 0, E_FIXED, 32'h0);
		set_entry(7, K_REG, 32'h8000_0001, 0, E_COUNT, '0); // count untouched by the write
		for (int i = 8; i < 16; i++) begin
			rnd_bits(23, r);
			set_entry(i, K_RND, arr_addr(r[22], r[21:0]), 1 + (i % 4), E_MODEL, '0);
		end
		set_entry(16, K_REG, 32'h8000_0001, 0, E_COUNT, '0);
	endtask

	// wishbone master, entered and left 1 ns after an edge
	task automatic bus_cycle(input logic wr, input logic [31:0] a,
		output logic [31:0] dat, output int lat);
		lat = 0;
		cyc = 1'b1;
		stb = 1'b1;
		we  = wr;
		adr = a;
		sel = 4'hF;
		do begin
			@(posedge clk_bus);
			#1 lat++;
		end while (!wbs_ack_o);
		dat = wbs_dat_o;
		@(posedge clk_bus); // ack taken on this edge, stb still high
		#1;
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
		@(posedge clk_bus); // idle cycle between requests
		#1;
	endtask

	always @(posedge clk_bus) begin
		cycles++;
		if (limit > 0 && cycles > limit) begin
			$display("timeout, no ack after %0d cycles", cycles);
			$display("Test failed");
			$finish;
		end
	end

	// flash reset pin, low cycles counted from the release of rst
	initial begin
		int low;
		low = 0;
		@(negedge rst);
		while (!flash_rst_n) begin
			@(posedge clk_bus);
			#1 low++;
		end
		assert (low == RESET_CYCLES) else begin
			$display("FAIL %0t flash_rst_n_o low cycles got %0d expected %0d", $time, low,
				RESET_CYCLES);
			errors++;
		end
	end

	initial begin
		logic [31:0] got, exp;
		int          lat, err0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = '0;
		sel = '0;
		model_delay = 0;
		errors = 0;
		passed = 0;
		arr_done = 0;
		cycles = 0;
		lfsr = 16'd77;
		limit = 0;
		load_table();
		limit = RESET_CYCLES + 20;
		for (int i = 0; i < N; i++)
			limit += ACCESS_CYCLES + delay_t[i] + 12; // worst case per entry
		@(negedge rst);
		repeat (4) begin
			@(posedge clk_bus);
			#1 assert (!wbs_ack_o) else begin
				$display("FAIL %0t wbs_ack_o got %b expected 0", $time, wbs_ack_o);
				errors++;
			end
		end
		for (int i = 0; i < N; i++) begin
			err0 = errors;
			model_delay = delay_t[i];
			bus_cycle(kind_t[i] == K_WR, addr_t[i], got, lat);
			case (mode_t[i])
				E_MODEL: exp = chip_word(addr_t[i]);
				E_COUNT: exp = arr_done;
				default: exp = val_t[i];
			endcase
			assert (got === exp) else begin
				$display("FAIL %0t wbs_dat_o got %h expected %h", $time, got, exp);
				errors++;
			end
			if (mode_t[i] == E_MODEL) begin
				arr_done++;
				assert (lat >= delay_t[i] + ACCESS_CYCLES) else begin
					$display("array read %0d acked too early after %0d cycles", i, lat);
					errors++;
				end
				if (i == 0) begin
					assert (lat >= RESET_CYCLES - 4) else begin
						$display("first read acked before the flash reset ended");
						errors++;
					end
				end
			end else begin
				assert (lat == 2) else begin
					$display("FAIL %0t ack latency got %0d expected 2", $time, lat);
					errors++;
				end
			end
			if (errors == err0)
				passed++;
			$display("test %0d kind %0d addr %h latency %0d %s", i, kind_t[i], addr_t[i],
				lat, (errors == err0) ? "ok" : "bad");
		end
		$display("%0d tests ok, %0d errors", passed, errors);
		if (errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

/* project.f */
flash_pkg.sv
flash_addr_decode.sv
flash_read_engine.sv
flash_result_latch.sv
wb_flash_reader.sv
tb_clock_gen.sv
tb_flash_model.sv
wb_flash_reader_properties.sv
tb_wb_flash_reader.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_wb_flash_reader \
	-f project.f -o tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$out" | grep -qx "Test passed"; then
	exit 0
fi
exit 1
